/* all.f */
+incdir+.
usbPePkg.sv
tokenBuffer.sv
epFifo.sv
epBank.sv
transactionCtrl.sv
usbPe.sv
tbUsbPe.sv

/* Bender.yml */
package:
  name: usbPe

sources:
  - include_dirs:
      - .
    files:
      - usbPePkg.sv
      - tokenBuffer.sv
      - epFifo.sv
      - epBank.sv
      - transactionCtrl.sv
      - usbPe.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tbUsbPe.sv

/* tbUsbPe.sv */
`timescale 1ns/1ns
`default_nettype none

`include "usbPe_settings.svh"

// Table driven testbench for the USB protocol engine core
module tbUsbPe
    import usbPePkg::*;
();

    localparam int numRows   = 18;
    localparam int clkPeriod = 40;

    localparam logic [1:0] opOut  = 2'd0;   // Token plus data packet
    localparam logic [1:0] opIn   = 2'd1;   // Token, then collect transmit bytes
    localparam logic [1:0] opPush = 2'd2;   // User fills an IN FIFO
    localparam logic [1:0] opPop  = 2'd3;   // User drains an OUT FIFO

    typedef struct packed {
        logic [1:0] op;
        logic [7:0] pid;          // Whole PID byte, check nibble included
        logic [3:0] ep;
        logic [4:0] len;          // Payload bytes
        logic       keep;         // keepPacket on last data byte
        logic [7:0] first;        // Payload byte i is first + i
        logic       expectData;   // Data lands or is sent
    } testRow_t;

    logic                     clk48_i;
    logic                     rst_i;
    logic                     rxAcceptNewData_o;
    usbByte_t                 rxData_i;
    logic                     rxIsLastByte_i;
    logic                     rxDataValid_i;
    logic                     keepPacket_i;
    logic                     txDataValid_o;
    logic                     txIsLastByte_o;
    usbByte_t                 txData_o;
    logic                     txAcceptNewData_i;
    epPush_t [`USB_NUM_EP-1:0] epInPush_i;
    logic    [`USB_NUM_EP-1:0] epInFull_o;
    logic    [`USB_NUM_EP-1:0] epOutPop_i;
    epPop_t  [`USB_NUM_EP-1:0] epOut_o;

    testRow_t   rows [numRows];
    string      rowName [numRows];
    int         rowCount;
    usbByte_t   pkt [32];                       // Packet being sent to the DUT
    logic [8:0] outModel [`USB_NUM_EP][32];     // Expected OUT FIFO contents
    int         outCount [`USB_NUM_EP];
    logic [8:0] inModel [`USB_NUM_EP][32];      // Expected IN stream
    int         inCount [`USB_NUM_EP];
    int         errors;
    integer     seed = 32'he52c_4f3a;

    usbPe dut0 (
        .clk48_i           (clk48_i),
        .rst_i             (rst_i),
        .rxAcceptNewData_o (rxAcceptNewData_o),
        .rxData_i          (rxData_i),
        .rxIsLastByte_i    (rxIsLastByte_i),
        .rxDataValid_i     (rxDataValid_i),
        .keepPacket_i      (keepPacket_i),
        .txDataValid_o     (txDataValid_o),
        .txIsLastByte_o    (txIsLastByte_o),
        .txData_o          (txData_o),
        .txAcceptNewData_i (txAcceptNewData_i),
        .epInPush_i        (epInPush_i),
        .epInFull_o        (epInFull_o),
        .epOutPop_i        (epOutPop_i),
        .epOut_o           (epOut_o)
    );

    always #(clkPeriod / 2) clk48_i = ~clk48_i;   // 48 MHz stand-in, 40 ns

    // ========================================================================
    // Helpers
    // ========================================================================

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic waitCycles(input int n);
        repeat (n) @(posedge clk48_i);
        #2;                                     // Drive point after the edge
    endtask

    task automatic addRow(input string name, input testRow_t row);
        rows[rowCount]    = row;
        rowName[rowCount] = name;
        rowCount++;
    endtask

    // Hold the byte until a cycle with accept high has passed
    task automatic sendByte(input usbByte_t b, input logic last, input logic keep);
        logic accepted;
        accepted       = 1'b0;
        rxDataValid_i  = 1'b1;
        rxData_i       = b;
        rxIsLastByte_i = last;
        keepPacket_i   = keep;
        while (!accepted) begin
            accepted = rxAcceptNewData_o;       // Register driven, stable here
            waitCycles(1);
        end
        rxDataValid_i  = 1'b0;
        rxIsLastByte_i = 1'b0;
    endtask

    task automatic sendPacket(input int n, input logic keep);
        int i;
        for (i = 0; i < n; i++) begin
            if (($random(seed) & 3) == 0) waitCycles(1);   // Random idle gap
            sendByte(pkt[i], i == n - 1, keep);
        end
    endtask

    // Token bytes in wire order, endpoint split over bytes 1 and 2
    task automatic sendToken(input logic [7:0] pid, input logic [3:0] ep);
        pkt[0] = pid;
        pkt[1] = {ep[0], 7'h2a};                // Address is never compared
        pkt[2] = {5'h15, ep[3:1]};              // CRC5 not checked either
        sendPacket(3, 1'b1);
    endtask

    task automatic sendData(input int len, input usbByte_t first, input logic keep);
        int i;
        pkt[0] = 8'hc3;                         // DATA0
        for (i = 0; i < len; i++) pkt[i + 1] = usbByte_t'(first + i);
        sendPacket(len + 1, keep);
    endtask

    task automatic pushInPacket(input int e, input int len, input usbByte_t first);
        epPush_t w;
        int      i;
        for (i = 0; i < len; i++) begin
            w              = '0;
            w.push         = 1'b1;
            w.entry.data   = usbByte_t'(first + i);
            w.entry.isLast = (i == len - 1);
            epInPush_i[e]  = w;
            inModel[e][inCount[e] + i] = {i == len - 1, usbByte_t'(first + i)};
            waitCycles(1);
        end
        inCount[e]    += len;
        w             = '0;
        w.commit      = 1'b1;                   // Publish whole packet
        epInPush_i[e] = w;
        waitCycles(1);
        epInPush_i[e] = '0;
    endtask

    task automatic popOutFifo(input string name, input int e);
        int i;
        for (i = 0; i < outCount[e]; i++) begin
            check(name, 1, epOut_o[e].avail);
            check(name, outModel[e][i], {epOut_o[e].head.isLast, epOut_o[e].head.data});
            epOutPop_i[e] = 1'b1;
            waitCycles(1);
            epOutPop_i[e] = 1'b0;
        end
        outCount[e] = 0;
        check(name, 0, epOut_o[e].avail);       // Nothing beyond the model
    endtask

    // Collect one packet under random accept stalls
    task automatic receiveInPacket(input string name, input int e);
        int   idx;
        int   cycles;
        logic done;
        logic seen;
        idx    = 0;
        cycles = 0;
        done   = 1'b0;
        seen   = 1'b0;
        while (!done) begin
            txAcceptNewData_i = (($random(seed) & 3) != 0);   // Stall about 1 in 4
            if (txDataValid_o) seen = 1'b1;
            if (txDataValid_o && txAcceptNewData_i) begin
                check(name, inModel[e][idx], {txIsLastByte_o, txData_o});
                idx++;
                done = txIsLastByte_o || (idx == inCount[e]);
            end
            // Valid must be up by the second cycle after the token's last byte
            if (!seen && cycles >= 1) begin
                $display("%s: no transmit data within two cycles of the IN token", name);
                errors++;
                done = 1'b1;
            end else if (cycles > 150) begin
                $display("%s: transmit packet never reached its last byte", name);
                errors++;
                done = 1'b1;
            end
            waitCycles(1);
            cycles++;
        end
        txAcceptNewData_i = 1'b0;
        inCount[e]        = 0;
        check(name, 0, txDataValid_o);          // Back in IDLE
    endtask

    task automatic checkNoTx(input string name);
        int i;
        for (i = 0; i < 8; i++) begin
            check(name, 0, txDataValid_o);
            waitCycles(1);
        end
    endtask

    task automatic runRow(input int r);
        testRow_t row;
        int       i;
        int       e;
        row = rows[r];
        e   = row.ep[1:0];
        case (row.op)
            opOut: begin
                sendToken(row.pid, row.ep);
                sendData(row.len, row.first, row.keep);
                if (row.expectData) begin
                    outModel[e][outCount[e]] = {1'b0, 8'hc3};   // PID byte is stored
                    for (i = 0; i < row.len; i++) begin
                        outModel[e][outCount[e] + 1 + i] =
                            {i == row.len - 1, usbByte_t'(row.first + i)};
                    end
                    outCount[e] += row.len + 1;
                end
                waitCycles(1);                  // Second cycle after the last byte
                for (i = 0; i < `USB_NUM_EP; i++) begin
                    check(rowName[r], outCount[i] != 0, epOut_o[i].avail);
                end
            end
            opIn: begin
                sendToken(row.pid, row.ep);
                if (row.expectData) receiveInPacket(rowName[r], e);
                else checkNoTx(rowName[r]);
            end
            opPush: begin
                pushInPacket(e, row.len, row.first);
                check(rowName[r], 0, epInFull_o[e]);
            end
            default: popOutFifo(rowName[r], e);
        endcase
    endtask

    // ========================================================================
    // Stimulus table and main sequence
    // ========================================================================

    initial begin
        int       r;
        int       e;
        txState_t st;
        clk48_i           = 1'b0;
        rst_i             = 1'b1;
        rxData_i          = '0;
        rxIsLastByte_i    = 1'b0;
        rxDataValid_i     = 1'b0;
        keepPacket_i      = 1'b0;
        txAcceptNewData_i = 1'b0;
        epInPush_i        = '0;
        epOutPop_i        = '0;
        errors            = 0;
        rowCount          = 0;
        for (e = 0; e < `USB_NUM_EP; e++) begin
            outCount[e] = 0;
            inCount[e]  = 0;
        end

        //            op      pid    ep     len    keep  first  data
        addRow("outEp0",       '{opOut,  8'he1, 4'd0, 5'd4,  1'b1, 8'h10, 1'b1});
        addRow("popEp0",       '{opPop,  8'h00, 4'd0, 5'd0,  1'b1, 8'h00, 1'b0});
        addRow("setupEp3",     '{opOut,  8'h2d, 4'd3, 5'd3,  1'b1, 8'h40, 1'b1});
        addRow("keepLowEp1",   '{opOut,  8'he1, 4'd1, 5'd5,  1'b0, 8'h20, 1'b0});
        addRow("fillEp2",      '{opOut,  8'he1, 4'd2, 5'd12, 1'b1, 8'h30, 1'b1});
        addRow("overflowEp2",  '{opOut,  8'he1, 4'd2, 5'd6,  1'b1, 8'h60, 1'b0});
        addRow("badNibble",    '{opOut,  8'hf1, 4'd1, 5'd3,  1'b1, 8'h70, 1'b0});
        addRow("epOutOfRange", '{opOut,  8'he1, 4'd5, 5'd3,  1'b1, 8'h78, 1'b0});
        addRow("dataPidStart", '{opOut,  8'hc3, 4'd0, 5'd3,  1'b1, 8'h80, 1'b0});
        addRow("popEp3",       '{opPop,  8'h00, 4'd3, 5'd0,  1'b1, 8'h00, 1'b0});
        addRow("popEp2",       '{opPop,  8'h00, 4'd2, 5'd0,  1'b1, 8'h00, 1'b0});
        addRow("popEp1",       '{opPop,  8'h00, 4'd1, 5'd0,  1'b1, 8'h00, 1'b0});
        addRow("pushEp1",      '{opPush, 8'h00, 4'd1, 5'd5,  1'b1, 8'ha0, 1'b0});
        addRow("inEp1",        '{opIn,   8'h69, 4'd1, 5'd0,  1'b1, 8'h00, 1'b1});
        addRow("inEmptyEp2",   '{opIn,   8'h69, 4'd2, 5'd0,  1'b1, 8'h00, 1'b0});
        addRow("pushEp3",      '{opPush, 8'h00, 4'd3, 5'd8,  1'b1, 8'hb0, 1'b0});
        addRow("inEp3",        '{opIn,   8'h69, 4'd3, 5'd0,  1'b1, 8'h00, 1'b1});
        addRow("popEp0Again",  '{opPop,  8'h00, 4'd0, 5'd0,  1'b1, 8'h00, 1'b0});

        repeat (5) @(posedge clk48_i);
        #2;
        rst_i = 1'b0;

        // Idle levels out of reset
        check("reset", 1, rxAcceptNewData_o);
        check("reset", 0, txDataValid_o);
        for (e = 0; e < `USB_NUM_EP; e++) check("reset", 0, epOut_o[e].avail);

        for (r = 0; r < rowCount; r++) begin
            runRow(r);
            st = dut0.ctrl0.state;
            $display("[%0t] row %0d %s finished, FSM in %s", $time, r, rowName[r], st.name());
        end

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog, 200 cycles per row plus slack
    initial begin
        #((numRows * 200 + 100) * clkPeriod);
        $display("Watchdog expired, the tests did not finish in time");
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* usbPe.sv */
`timescale 1ns/1ns
`default_nettype none

`include "usbPe_settings.svh"

// USB full-speed protocol engine core
module usbPe
    import usbPePkg::*;
(
    input  logic                       clk48_i,
    input  logic                       rst_i,

    // Receive from serial frontend
    output logic                       rxAcceptNewData_o,
    input  usbByte_t                   rxData_i,
    input  logic                       rxIsLastByte_i,
    input  logic                       rxDataValid_i,
    input  logic                       keepPacket_i,

    // Transmit to serial frontend
    output logic                       txDataValid_o,
    output logic                       txIsLastByte_o,
    output usbByte_t                   txData_o,
    input  logic                       txAcceptNewData_i,

    // User side, device centric naming
    input  epPush_t  [`USB_NUM_EP-1:0] epInPush_i,
    output logic     [`USB_NUM_EP-1:0] epInFull_o,
    input  logic     [`USB_NUM_EP-1:0] epOutPop_i,
    output epPop_t   [`USB_NUM_EP-1:0] epOut_o
);

    tokenBuf_u                token;
    logic                     tokenFull;
    logic                     tokenClear;
    logic                     tokenWrite;
    logic [`USB_EP_SEL_W-1:0] epSel;
    epPush_t                  outWrite;
    logic                     outFull;
    epPop_t                   txHead;
    logic                     txPop;

    transactionCtrl ctrl0 (
        .clk48_i      (clk48_i),
        .rst_i        (rst_i),
        .rxValid_i    (rxDataValid_i),
        .rxLast_i     (rxIsLastByte_i),
        .rxKeep_i     (keepPacket_i),
        .rxByte_i     (rxData_i),
        .rxAccept_o   (rxAcceptNewData_o),
        .token_i      (token),
        .tokenFull_i  (tokenFull),
        .tokenClear_o (tokenClear),
        .tokenWrite_o (tokenWrite),
        .epSel_o      (epSel),
        .outWrite_o   (outWrite),
        .outFull_i    (outFull),
        .txHead_i     (txHead),
        .txAccept_i   (txAcceptNewData_i),
        .txValid_o    (txDataValid_o),
        .txData_o     (txData_o),
        .txLast_o     (txIsLastByte_o),
        .txPop_o      (txPop)
    );

    tokenBuffer tokBuf0 (
        .clk48_i     (clk48_i),
        .rst_i       (rst_i),
        .clear_i     (tokenClear),
        .byteValid_i (tokenWrite),
        .byte_i      (rxData_i),
        .full_o      (tokenFull),
        .token_o     (token)
    );

    epBank bank0 (
        .clk48_i    (clk48_i),
        .rst_i      (rst_i),
        .epSel_i    (epSel),
        .outWrite_i (outWrite),
        .inPush_i   (epInPush_i),
        .outPop_i   (epOutPop_i),
        .txPop_i    (txPop),
        .outFull_o  (outFull),
        .inFull_o   (epInFull_o),
        .out_o      (epOut_o),
        .tx_o       (txHead)
    );

endmodule

`default_nettype wire

/* transactionCtrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "usbPe_settings.svh"

// Receive status, token decode and transaction FSM
module transactionCtrl
    import usbPePkg::*;
(
    input  logic                     clk48_i,
    input  logic                     rst_i,

    input  logic                     rxValid_i,
    input  logic                     rxLast_i,
    input  logic                     rxKeep_i,
    input  usbByte_t                 rxByte_i,
    output logic                     rxAccept_o,

    input  tokenBuf_u                token_i,
    input  logic                     tokenFull_i,
    output logic                     tokenClear_o,
    output logic                     tokenWrite_o,

    output logic [`USB_EP_SEL_W-1:0] epSel_o,
    output epPush_t                  outWrite_o,
    input  logic                     outFull_i,

    input  epPop_t                   txHead_i,
    input  logic                     txAccept_i,
    output logic                     txValid_o,
    output usbByte_t                 txData_o,
    output logic                     txLast_o,
    output logic                     txPop_o
);

    txState_t                 state;
    logic [`USB_EP_SEL_W-1:0] epSel;
    logic                     receiveDone;      // Cycle after last rx byte
    logic                     receiveSuccess;   // Cleared by any rx error

    logic         rxXfer;
    logic         targetFull;
    logic         inData;
    tokenFields_t tok;
    logic         pidOk;
    logic         epOk;
    logic         tokenOk;
    logic         isOutLike;
    logic         isIn;

    // ========================================================================
    // Receive side
    // ========================================================================

    assign rxAccept_o = !receiveDone;   // Only drop is the done cycle
    assign rxXfer     = rxValid_i && rxAccept_o;
    assign inData     = (state == AWAIT_DATA);
    assign targetFull = inData ? outFull_i : tokenFull_i;

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            receiveDone    <= 1'b0;
            receiveSuccess <= 1'b1;
        end else if (receiveDone) begin
            receiveDone    <= 1'b0;     // Ready for next packet
            receiveSuccess <= 1'b1;
        end else if (rxXfer) begin
            // Overflow or frontend reject fails the packet
            if (targetFull || (rxLast_i && !rxKeep_i)) begin
                receiveSuccess <= 1'b0;
            end
            receiveDone <= rxLast_i;
        end
    end

    // Token buffer only listens while idle
    assign tokenWrite_o = rxXfer && (state == IDLE);
    assign tokenClear_o = receiveDone;

    // Data packet goes to selected OUT FIFO, PID byte included
    assign outWrite_o.push        = rxXfer && inData;
    assign outWrite_o.entry.data  = rxByte_i;
    assign outWrite_o.entry.isLast = rxLast_i;
    assign outWrite_o.commit      = receiveDone && inData && receiveSuccess;
    assign outWrite_o.discard     = receiveDone && inData && !receiveSuccess;

    // ========================================================================
    // Token decode, valid in the done cycle
    // ========================================================================

    assign tok       = token_i.fields;
    assign pidOk     = (tok.pid[7:4] == ~tok.pid[3:0]);  // Check nibble
    assign epOk      = (tok.endp < `USB_NUM_EP);
    assign isOutLike = (tok.pid[3:0] == `USB_PID_OUT) || (tok.pid[3:0] == `USB_PID_SETUP);
    assign isIn      = (tok.pid[3:0] == `USB_PID_IN);
    assign tokenOk   = receiveDone && receiveSuccess && tokenFull_i && pidOk && epOk;

    // ========================================================================
    // Transaction FSM
    // ========================================================================

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            state <= IDLE;
            epSel <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (tokenOk && (isOutLike || isIn)) begin
                        epSel <= tok.endp[`USB_EP_SEL_W-1:0];
                        state <= isIn ? SENDING : AWAIT_DATA;
                    end
                end
                AWAIT_DATA: begin
                    if (receiveDone) begin
                        state <= IDLE;  // Committed or rolled back by now
                    end
                end
                SENDING: begin
                    // Nothing committed, or the last byte just left
                    if (!txHead_i.avail || (txPop_o && txLast_o)) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign epSel_o = epSel;

    // Transmit straight from the IN FIFO head
    assign txValid_o = (state == SENDING) && txHead_i.avail;
    assign txData_o  = txHead_i.head.data;
    assign txLast_o  = txHead_i.head.isLast;
    assign txPop_o   = txValid_o && txAccept_i;   // Stall holds the head

endmodule

`default_nettype wire

/* epBank.sv */
`timescale 1ns/1ns
`default_nettype none

`include "usbPe_settings.svh"

// All endpoint FIFO pairs
// OUT FIFOs are filled by the receive path, drained by the user
// IN FIFOs are filled by the user, drained by the transmit path
module epBank
    import usbPePkg::*;
(
    input  logic                         clk48_i,
    input  logic                         rst_i,
    input  logic [`USB_EP_SEL_W-1:0]     epSel_i,     // Endpoint of current transaction
    input  epPush_t                      outWrite_i,  // Receive path write port
    input  epPush_t  [`USB_NUM_EP-1:0]   inPush_i,    // User write ports
    input  logic     [`USB_NUM_EP-1:0]   outPop_i,    // User pop strobes
    input  logic                         txPop_i,
    output logic                         outFull_o,   // Selected OUT FIFO full
    output logic     [`USB_NUM_EP-1:0]   inFull_o,
    output epPop_t   [`USB_NUM_EP-1:0]   out_o,
    output epPop_t                       tx_o         // Selected IN FIFO head
);

    logic   [`USB_NUM_EP-1:0] outFull;
    epPop_t [`USB_NUM_EP-1:0] inHead;

    for (genvar e = 0; e < `USB_NUM_EP; e++) begin : gEp
        logic    isSel;
        epPush_t outWrite;

        assign isSel    = (epSel_i == `USB_EP_SEL_W'(e));
        assign outWrite = isSel ? outWrite_i : '0;   // Idle strobes when not selected

        // Host to device
        epFifo outFifo (
            .clk48_i (clk48_i),
            .rst_i   (rst_i),
            .push_i  (outWrite),
            .pop_i   (outPop_i[e]),
            .full_o  (outFull[e]),
            .out_o   (out_o[e])
        );

        // Device to host
        epFifo inFifo (
            .clk48_i (clk48_i),
            .rst_i   (rst_i),
            .push_i  (inPush_i[e]),
            .pop_i   (txPop_i && isSel),
            .full_o  (inFull_o[e]),
            .out_o   (inHead[e])
        );
    end

    // Selected endpoint muxes
    assign outFull_o = outFull[epSel_i];
    assign tx_o      = inHead[epSel_i];

endmodule

`default_nettype wire

/* epFifo.sv */
`timescale 1ns/1ns
`default_nettype none

`include "usbPe_settings.svh"

// Packet FIFO with speculative write side
// Reader only sees whole, committed packets
module epFifo
    import usbPePkg::*;
(
    input  logic    clk48_i,
    input  logic    rst_i,
    input  epPush_t push_i,
    input  logic    pop_i,
    output logic    full_o,
    output epPop_t  out_o
);

    localparam int addrW = `USB_FIFO_PTR_W - 1;   // Top bit is the wrap bit

    epEntry_t mem [`USB_FIFO_DEPTH];

    logic [`USB_FIFO_PTR_W-1:0] wrSpec;     // Next free slot, uncommitted
    logic [`USB_FIFO_PTR_W-1:0] wrCommit;   // End of published data
    logic [`USB_FIFO_PTR_W-1:0] rdPtr;

    logic doPush;
    logic doPop;

    // ========================================================================
    // Status
    // ========================================================================

    // Full is judged against the speculative pointer, pending bytes take room
    assign full_o = (wrSpec[addrW] != rdPtr[addrW]) &&
                    (wrSpec[addrW-1:0] == rdPtr[addrW-1:0]);

    assign out_o.avail = (wrCommit != rdPtr);
    assign out_o.head  = mem[rdPtr[addrW-1:0]];   // Async read of head slot

    assign doPush = push_i.push && !full_o;       // Push into a full FIFO is lost
    assign doPop  = pop_i && out_o.avail;

    // ========================================================================
    // Pointers
    // ========================================================================

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            wrSpec   <= '0;
            wrCommit <= '0;
            rdPtr    <= '0;
        end else begin
            if (push_i.discard) begin
                wrSpec <= wrCommit;               // Roll back partial packet
            end else if (doPush) begin
                wrSpec <= wrSpec + 1'b1;
            end

            if (push_i.commit) begin
                wrCommit <= wrSpec;               // Visible to reader next cycle
            end

            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk48_i) begin
        if (doPush) begin
            mem[wrSpec[addrW-1:0]] <= push_i.entry;
        end
    end

endmodule

`default_nettype wire

/* tokenBuffer.sv */
`timescale 1ns/1ns
`default_nettype none

// Holds the first three bytes of a transaction start packet
module tokenBuffer
    import usbPePkg::*;
(
    input  logic      clk48_i,
    input  logic      rst_i,
    input  logic      clear_i,      // Empty for next packet
    input  logic      byteValid_i,
    input  usbByte_t  byte_i,
    output logic      full_o,
    output tokenBuf_u token_o
);

    logic [1:0] count;              // Bytes stored so far, saturates at 3
    tokenBuf_u  tokenReg;
    logic       store;

    assign store  = byteValid_i && !full_o;   // Extra bytes fall on the floor
    assign full_o = (count == 2'd3);

    always_ff @(posedge clk48_i) begin
        if (rst_i || clear_i) begin
            count <= 2'd0;
        end else if (store) begin
            count <= count + 2'd1;
        end
    end

    // Shift down from the top so the PID ends in bytes[0] after three bytes
    always_ff @(posedge clk48_i) begin
        if (store) begin
            tokenReg.bytes <= {byte_i, tokenReg.bytes[2:1]};
        end
    end

    assign token_o = tokenReg;

endmodule

`default_nettype wire

/* usbPePkg.sv */
`default_nettype none

`include "usbPe_settings.svh"

package usbPePkg;

    typedef logic [`USB_BYTE_W-1:0] usbByte_t;

    // One FIFO slot
    typedef struct packed {
        logic     isLast;   // Final byte of its packet
        usbByte_t data;
    } epEntry_t;

    // Token layout as it lands in the buffer, PID byte lowest
    // Wire order is LSB first, so endp straddles bytes 1 and 2
    typedef struct packed {
        logic [4:0] crc;
        logic [3:0] endp;
        logic [6:0] addr;   // Not compared, every token is ours
        usbByte_t   pid;
    } tokenFields_t;

    // Written bytewise by tokenBuffer, read fieldwise by the controller
    typedef union packed {
        tokenFields_t       fields;
        usbByte_t     [2:0] bytes;
    } tokenBuf_u;

    // FIFO write port
    typedef struct packed {
        logic     push;     // Store entry
        epEntry_t entry;
        logic     commit;   // Publish everything pushed so far
        logic     discard;  // Roll back to last commit
    } epPush_t;

    // FIFO read side
    typedef struct packed {
        logic     avail;    // Committed data waiting
        epEntry_t head;
    } epPop_t;

    typedef enum logic [1:0] {
        IDLE,
        AWAIT_DATA,
        SENDING
    } txState_t;

endpackage

`default_nettype wire

/* usbPe_settings.svh */
`ifndef USBPE_SETTINGS_SVH
`define USBPE_SETTINGS_SVH

// ===========================================================================
// Endpoint and FIFO sizing
// ===========================================================================

`define USB_NUM_EP      4   // Endpoints, each with an OUT and an IN FIFO
`define USB_EP_SEL_W    2   // Enough bits to name every endpoint
`define USB_FIFO_DEPTH  16  // Entries per FIFO
`define USB_FIFO_PTR_W  5   // Address bits plus one wrap bit

`define USB_BYTE_W      8   // Frontend moves whole bytes

// ===========================================================================
// Token PID codes, low nibble of the PID byte
// ===========================================================================

`define USB_PID_OUT     4'b0001
`define USB_PID_IN      4'b1001
`define USB_PID_SETUP   4'b1101

`endif
